// File: hdl/secp_cmd_parser.sv
`timescale 1ns/100ps
`default_nettype none

`include "secp_defs.svh"

module secp_cmd_parser
  import secp_pkg::*;
(
  input  wire                           i_clk,
  input  wire                           i_rst,
  input  wire [`SECP_WORD_BITS-1:0]     i_cmd_dat,
  input  wire                           i_cmd_val,
  input  wire                           i_cmd_sop,
  input  wire                           i_cmd_eop,
  output logic                          o_cmd_rdy,
  output logic                          o_rf_we,
  output logic [`SECP_RF_ADDR_BITS-1:0] o_rf_addr,
  output logic [`SECP_WORD_BITS-1:0]    o_rf_dat,
  output logic [`SECP_NUM_UNITS-1:0]    o_job_val,
  output mult_job_t                     o_job,
  input  wire [`SECP_NUM_UNITS-1:0]     i_unit_busy
);

  localparam int UW = $clog2(`SECP_NUM_UNITS);
  localparam int WB = `SECP_WORD_BITS;
  localparam logic [`SECP_RF_ADDR_BITS-1:0] RF_HDR = `SECP_RF_HDR;
  localparam logic [`SECP_RF_ADDR_BITS-1:0] RF_IDX = `SECP_RF_IDX;
  localparam logic [`SECP_RF_ADDR_BITS-1:0] RF_A = `SECP_RF_A;
  localparam logic [`SECP_RF_ADDR_BITS-1:0] RF_B = `SECP_RF_B;
  localparam logic [2:0] LAST_OP_WORD = 3'(2 * `SECP_OP_WORDS - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_GET_INDEX,
    ST_GET_OPERANDS,
    ST_DISPATCH,
    ST_IGNORE
  } state_t;

  state_t                    state;
  header_t                   hdr;
  mod_sel_t                  mod_sel_q;
  logic [`SECP_NUM_BITS-1:0] op_a;
  logic [`SECP_NUM_BITS-1:0] op_b;
  logic [`SECP_NUM_BITS-1:0] modulus;
  logic [WB-1:0]             index_q;
  logic [2:0]                word_cnt;
  logic [UW-1:0]             unit_ptr;
  logic                      cmd_fire;
  logic                      issue;

  assign hdr      = header_t'(i_cmd_dat);
  assign cmd_fire = i_cmd_val && o_cmd_rdy;
  assign modulus  = secp_modulus(mod_sel_q);
  assign issue    = (state == ST_DISPATCH) && !i_unit_busy[unit_ptr];

  // Strobe only the unit the round-robin pointer selects
  always_comb begin
    o_job_val = '0;
    if (issue) begin
      o_job_val[unit_ptr] = 1'b1;
    end
  end

  always_comb begin
    o_job.a            = op_a;
    o_job.b            = op_b;
    o_job.mod_sel      = mod_sel_q;
    o_job.index        = index_q;
    o_job.out_of_range = (op_a >= modulus) || (op_b >= modulus);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      o_cmd_rdy <= 1'b0;
      o_rf_we   <= 1'b0;
      word_cnt  <= '0;
      unit_ptr  <= '0;
    end else begin
      o_rf_we <= 1'b0;
      case (state)
        ST_IDLE: begin
          o_cmd_rdy <= 1'b1;
          word_cnt  <= '0;
          if (cmd_fire) begin
            if (i_cmd_sop && hdr.cmd == `SECP_CMD_MULT_MOD) begin
              o_rf_we <= 1'b1;
              state   <= ST_GET_INDEX;
            end else if (!i_cmd_eop) begin
              state <= ST_IGNORE;
            end
          end
        end
        ST_GET_INDEX: begin
          if (cmd_fire) begin
            o_rf_we <= 1'b1;
            state   <= ST_GET_OPERANDS;
          end
        end
        ST_GET_OPERANDS: begin
          if (cmd_fire) begin
            o_rf_we  <= 1'b1;
            word_cnt <= word_cnt + 3'd1;
            // Stall the stream until the job is handed off
            if (word_cnt == LAST_OP_WORD) begin
              o_cmd_rdy <= 1'b0;
              state     <= ST_DISPATCH;
            end
          end
        end
        ST_DISPATCH: begin
          if (issue) begin
            unit_ptr  <= unit_ptr + 1'b1;
            o_cmd_rdy <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        ST_IGNORE: begin
          if (cmd_fire && i_cmd_eop) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Operand assembly and register file write data
  always_ff @(posedge i_clk) begin
    if (cmd_fire) begin
      o_rf_dat <= i_cmd_dat;
      case (state)
        ST_IDLE: begin
          o_rf_addr <= RF_HDR;
          mod_sel_q <= hdr.mod_sel;
        end
        ST_GET_INDEX: begin
          o_rf_addr <= RF_IDX;
          index_q   <= i_cmd_dat;
        end
        ST_GET_OPERANDS: begin
          if (!word_cnt[2]) begin
            o_rf_addr                    <= RF_A + {2'b00, word_cnt[1:0]};
            op_a[word_cnt[1:0]*WB +: WB] <= i_cmd_dat;
          end else begin
            o_rf_addr                    <= RF_B + {2'b00, word_cnt[1:0]};
            op_b[word_cnt[1:0]*WB +: WB] <= i_cmd_dat;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Dispatch must never double-issue or hit a unit still holding a job
  a_job_onehot_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot0(o_job_val) && ((o_job_val & i_unit_busy) == '0));

endmodule

`default_nettype wire

// File: hdl/secp_mod_mult_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "secp_defs.svh"

module secp_mod_mult_unit
  import secp_pkg::*;
(
  input  wire       i_clk,
  input  wire       i_rst,
  input  wire       i_job_val,
  input  mult_job_t i_job,
  output logic      o_busy,
  output logic      o_done,
  output mult_res_t o_res,
  input  wire       i_take
);

  localparam int NB = `SECP_NUM_BITS;
  localparam int CW = $clog2(NB + 1);
  localparam logic [CW-1:0] LAST_BIT = CW'(NB);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } state_t;

  state_t                     state;
  logic [CW-1:0]              bit_cnt;
  logic [NB-1:0]              a_q;
  logic [NB-1:0]              b_sh;
  logic [NB-1:0]              m_q;
  logic [NB-1:0]              acc;
  logic [`SECP_WORD_BITS-1:0] index_q;
  logic                       oor_q;
  logic [NB+1:0]              sum;
  logic [NB+1:0]              red1;
  logic [NB+1:0]              red2;

  assign o_busy = (state != ST_IDLE);
  assign o_done = (state == ST_DONE);

  assign o_res.product      = acc;
  assign o_res.index        = index_q;
  assign o_res.out_of_range = oor_q;

  // One step of 2*acc + bit*a, brought back below the modulus
  always_comb begin
    sum  = {1'b0, acc, 1'b0} + (b_sh[NB-1] ? {2'b00, a_q} : '0);
    red1 = (sum >= {2'b00, m_q}) ? sum - {2'b00, m_q} : sum;
    red2 = (red1 >= {2'b00, m_q}) ? red1 - {2'b00, m_q} : red1;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          bit_cnt <= '0;
          if (i_job_val) begin
            // Out of range jobs skip straight to a zero result
            state <= i_job.out_of_range ? ST_DONE : ST_RUN;
          end
        end
        ST_RUN: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == LAST_BIT) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (i_take) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE && i_job_val) begin
      a_q     <= i_job.a;
      b_sh    <= i_job.b;
      m_q     <= secp_modulus(i_job.mod_sel);
      index_q <= i_job.index;
      oor_q   <= i_job.out_of_range;
      acc     <= '0;
    end else if (state == ST_RUN && bit_cnt != LAST_BIT) begin
      acc  <= red2[NB-1:0];
      b_sh <= b_sh << 1;
    end
  end

  // The dispatcher only targets idle units
  a_no_job_when_busy: assert property (@(posedge i_clk) disable iff (i_rst)
    i_job_val |-> !o_busy);

endmodule

`default_nettype wire

// File: hdl/secp_mult_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "secp_defs.svh"

module secp_mult_top
  import secp_pkg::*;
(
  input  wire                           i_clk,
  input  wire                           i_rst,
  input  wire [`SECP_WORD_BITS-1:0]     i_cmd_dat,
  input  wire                           i_cmd_val,
  input  wire                           i_cmd_sop,
  input  wire                           i_cmd_eop,
  output logic                          o_cmd_rdy,
  output logic [`SECP_WORD_BITS-1:0]    o_rpl_dat,
  output logic                          o_rpl_val,
  output logic                          o_rpl_sop,
  output logic                          o_rpl_eop,
  input  wire                           i_rpl_rdy,
  input  wire                           i_dbg_rd,
  input  wire [`SECP_RF_ADDR_BITS-1:0]  i_dbg_addr,
  output logic [`SECP_WORD_BITS-1:0]    o_dbg_dat,
  output logic                          o_dbg_val
);

  logic                          rf_we;
  logic [`SECP_RF_ADDR_BITS-1:0] rf_addr;
  logic [`SECP_WORD_BITS-1:0]    rf_dat;
  logic [`SECP_NUM_UNITS-1:0]    job_val;
  logic [`SECP_NUM_UNITS-1:0]    unit_busy;
  logic [`SECP_NUM_UNITS-1:0]    unit_done;
  logic [`SECP_NUM_UNITS-1:0]    unit_take;
  mult_job_t                     job;
  mult_res_t                     unit_res [`SECP_NUM_UNITS];

  secp_cmd_parser u_secp_cmd_parser (
    .i_clk       ( i_clk     ),
    .i_rst       ( i_rst     ),
    .i_cmd_dat   ( i_cmd_dat ),
    .i_cmd_val   ( i_cmd_val ),
    .i_cmd_sop   ( i_cmd_sop ),
    .i_cmd_eop   ( i_cmd_eop ),
    .o_cmd_rdy   ( o_cmd_rdy ),
    .o_rf_we     ( rf_we     ),
    .o_rf_addr   ( rf_addr   ),
    .o_rf_dat    ( rf_dat    ),
    .o_job_val   ( job_val   ),
    .o_job       ( job       ),
    .i_unit_busy ( unit_busy )
  );

  secp_reg_file u_secp_reg_file (
    .i_clk    ( i_clk      ),
    .i_we     ( rf_we      ),
    .i_waddr  ( rf_addr    ),
    .i_wdat   ( rf_dat     ),
    .i_rd     ( i_dbg_rd   ),
    .i_raddr  ( i_dbg_addr ),
    .o_rdat   ( o_dbg_dat  ),
    .o_rd_val ( o_dbg_val  )
  );

  // All units share the job bus, the one-hot strobe picks the target
  for (genvar g = 0; g < `SECP_NUM_UNITS; g++) begin : g_unit
    secp_mod_mult_unit u_secp_mod_mult_unit (
      .i_clk     ( i_clk        ),
      .i_rst     ( i_rst        ),
      .i_job_val ( job_val[g]   ),
      .i_job     ( job          ),
      .o_busy    ( unit_busy[g] ),
      .o_done    ( unit_done[g] ),
      .o_res     ( unit_res[g]  ),
      .i_take    ( unit_take[g] )
    );
  end

  secp_reply_collector u_secp_reply_collector (
    .i_clk     ( i_clk     ),
    .i_rst     ( i_rst     ),
    .i_done    ( unit_done ),
    .i_res     ( unit_res  ),
    .o_take    ( unit_take ),
    .o_rpl_dat ( o_rpl_dat ),
    .o_rpl_val ( o_rpl_val ),
    .o_rpl_sop ( o_rpl_sop ),
    .o_rpl_eop ( o_rpl_eop ),
    .i_rpl_rdy ( i_rpl_rdy )
  );

endmodule

`default_nettype wire

// File: hdl/secp_pkg.sv
`default_nettype none

`include "secp_defs.svh"

package secp_pkg;

  typedef enum logic {
    MOD_P = 1'b0,
    MOD_N = 1'b1
  } mod_sel_t;

  // Command header, code in the low byte
  typedef struct packed {
    logic [`SECP_WORD_BITS-10:0] rsvd;
    mod_sel_t                    mod_sel;
    logic [7:0]                  cmd;
  } header_t;

  typedef struct packed {
    logic [`SECP_NUM_BITS-1:0]  a;
    logic [`SECP_NUM_BITS-1:0]  b;
    mod_sel_t                   mod_sel;
    logic [`SECP_WORD_BITS-1:0] index;
    logic                       out_of_range;
  } mult_job_t;

  typedef struct packed {
    logic [`SECP_NUM_BITS-1:0]  product;
    logic [`SECP_WORD_BITS-1:0] index;
    logic                       out_of_range;
  } mult_res_t;

  // Field prime and group order of secp256k1
  localparam logic [`SECP_NUM_BITS-1:0] SECP_P =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;
  localparam logic [`SECP_NUM_BITS-1:0] SECP_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  function automatic logic [`SECP_NUM_BITS-1:0] secp_modulus(input mod_sel_t sel);
    return (sel == MOD_N) ? SECP_N : SECP_P;
  endfunction

endpackage

`default_nettype wire

// File: hdl/secp_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "secp_defs.svh"

module secp_reg_file (
  input  wire                           i_clk,
  input  wire                           i_we,
  input  wire [`SECP_RF_ADDR_BITS-1:0]  i_waddr,
  input  wire [`SECP_WORD_BITS-1:0]     i_wdat,
  input  wire                           i_rd,
  input  wire [`SECP_RF_ADDR_BITS-1:0]  i_raddr,
  output logic [`SECP_WORD_BITS-1:0]    o_rdat,
  output logic                          o_rd_val
);

  logic [`SECP_WORD_BITS-1:0] mem [`SECP_RF_DEPTH];
  logic [`SECP_WORD_BITS-1:0] rdat_q;
  logic                       rd_q;

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdat;
    end
  end

  // First stage is the memory read register
  always_ff @(posedge i_clk) begin
    rdat_q <= mem[i_raddr];
    rd_q   <= i_rd;
  end

  // Output register, data lands two cycles after the strobe
  always_ff @(posedge i_clk) begin
    o_rdat   <= rdat_q;
    o_rd_val <= rd_q;
  end

endmodule

`default_nettype wire

// File: hdl/secp_reply_collector.sv
`timescale 1ns/100ps
`default_nettype none

`include "secp_defs.svh"

module secp_reply_collector
  import secp_pkg::*;
(
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire [`SECP_NUM_UNITS-1:0]  i_done,
  input  mult_res_t                  i_res [`SECP_NUM_UNITS],
  output logic [`SECP_NUM_UNITS-1:0] o_take,
  output logic [`SECP_WORD_BITS-1:0] o_rpl_dat,
  output logic                       o_rpl_val,
  output logic                       o_rpl_sop,
  output logic                       o_rpl_eop,
  input  wire                        i_rpl_rdy
);

  localparam int UW = $clog2(`SECP_NUM_UNITS);
  localparam int WB = `SECP_WORD_BITS;
  localparam logic [2:0] LAST_WORD = 3'(`SECP_RPL_WORDS - 1);

  typedef enum logic {
    ST_WAIT,
    ST_SEND
  } state_t;

  state_t        state;
  logic [UW-1:0] unit_ptr;
  logic [2:0]    word_cnt;
  logic [1:0]    prod_word;
  mult_res_t     res_q;
  logic          grab;

  // Same order as the parser's dispatch pointer
  assign grab = (state == ST_WAIT) && i_done[unit_ptr];

  always_comb begin
    o_take = '0;
    if (grab) begin
      o_take[unit_ptr] = 1'b1;
    end
  end

  assign o_rpl_val = (state == ST_SEND);
  assign o_rpl_sop = (word_cnt == 3'd0);
  assign o_rpl_eop = (word_cnt == LAST_WORD);
  assign prod_word = word_cnt[1:0] - 2'd2;

  // Word 0 status, word 1 index, then product LSW first
  always_comb begin
    case (word_cnt)
      3'd0:    o_rpl_dat = {{(WB-1){1'b0}}, res_q.out_of_range};
      3'd1:    o_rpl_dat = res_q.index;
      default: o_rpl_dat = res_q.product[prod_word*WB +: WB];
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_WAIT;
      unit_ptr <= '0;
      word_cnt <= '0;
    end else begin
      case (state)
        ST_WAIT: begin
          word_cnt <= '0;
          if (grab) begin
            state <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (i_rpl_rdy) begin
            word_cnt <= word_cnt + 3'd1;
            if (word_cnt == LAST_WORD) begin
              word_cnt <= '0;
              unit_ptr <= unit_ptr + 1'b1;
              state    <= ST_WAIT;
            end
          end
        end
        default: state <= ST_WAIT;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (grab) begin
      res_q <= i_res[unit_ptr];
    end
  end

  a_rpl_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_rpl_val && !i_rpl_rdy) |=> $stable(o_rpl_dat));

endmodule

`default_nettype wire

// File: include/secp_defs.svh
`ifndef SECP_DEFS_SVH
`define SECP_DEFS_SVH

// Stream and operand widths
`define SECP_WORD_BITS 64
`define SECP_NUM_BITS 256
`define SECP_OP_WORDS 4

// Number of parallel multiplier units
`define SECP_NUM_UNITS 4

// Command code for a modular multiply
`define SECP_CMD_MULT_MOD 8'h10

// Register file geometry and word offsets
`define SECP_RF_DEPTH 16
`define SECP_RF_ADDR_BITS 4
`define SECP_RF_HDR 0
`define SECP_RF_IDX 1
`define SECP_RF_A 2
`define SECP_RF_B 6

// Reply length in stream words
`define SECP_RPL_WORDS 6

`endif

// File: project.f
+incdir+include
hdl/secp_pkg.sv
hdl/secp_cmd_parser.sv
hdl/secp_reg_file.sv
hdl/secp_mod_mult_unit.sv
hdl/secp_reply_collector.sv
hdl/secp_mult_top.sv
verif/tb_secp_mult.sv

// File: verif/tb_secp_mult.sv
`timescale 1ns/100ps
`default_nettype none

`include "secp_defs.svh"

module tb_secp_mult;

  localparam int WB = `SECP_WORD_BITS;
  localparam int NB = `SECP_NUM_BITS;
  localparam logic [31:0] SEED = 32'ha461_2279;
  localparam int N_P_CMDS = 6;
  localparam int N_N_CMDS = 6;
  localparam int N_OOR_CMDS = 4;
  localparam int N_SKIP_CMDS = 3;
  localparam int N_BURST_CMDS = 20;
  localparam int NUM_CMDS = N_P_CMDS + N_N_CMDS + N_OOR_CMDS + N_SKIP_CMDS + N_BURST_CMDS;
  // Each command as if it ran alone through a unit, plus reply and stall slack
  localparam longint TIMEOUT_NS = longint'(NUM_CMDS) * (257 + 20) * 20 + 20000;

  // secp256k1 field prime and group order
  localparam logic [NB-1:0] P_PRIME =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;
  localparam logic [NB-1:0] N_ORDER =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  logic                          i_clk;
  logic                          i_rst;
  logic [WB-1:0]                 i_cmd_dat;
  logic                          i_cmd_val;
  logic                          i_cmd_sop;
  logic                          i_cmd_eop;
  logic                          o_cmd_rdy;
  logic [WB-1:0]                 o_rpl_dat;
  logic                          o_rpl_val;
  logic                          o_rpl_sop;
  logic                          o_rpl_eop;
  logic                          i_rpl_rdy;
  logic                          i_dbg_rd;
  logic [`SECP_RF_ADDR_BITS-1:0] i_dbg_addr;
  logic [WB-1:0]                 o_dbg_dat;
  logic                          o_dbg_val;

  logic [31:0]   stim_state;
  logic [31:0]   rdy_state;
  logic          rdy_random;
  logic          exp_status [$];
  logic [WB-1:0] exp_index [$];
  logic [NB-1:0] exp_prod [$];
  logic [WB-1:0] last_rf [`SECP_RF_DEPTH];
  int            rpl_word;
  int            cmds_sent;
  int            replies_rcv;

  secp_mult_top u_secp_mult_top (
    .i_clk      ( i_clk      ),
    .i_rst      ( i_rst      ),
    .i_cmd_dat  ( i_cmd_dat  ),
    .i_cmd_val  ( i_cmd_val  ),
    .i_cmd_sop  ( i_cmd_sop  ),
    .i_cmd_eop  ( i_cmd_eop  ),
    .o_cmd_rdy  ( o_cmd_rdy  ),
    .o_rpl_dat  ( o_rpl_dat  ),
    .o_rpl_val  ( o_rpl_val  ),
    .o_rpl_sop  ( o_rpl_sop  ),
    .o_rpl_eop  ( o_rpl_eop  ),
    .i_rpl_rdy  ( i_rpl_rdy  ),
    .i_dbg_rd   ( i_dbg_rd   ),
    .i_dbg_addr ( i_dbg_addr ),
    .o_dbg_dat  ( o_dbg_dat  ),
    .o_dbg_val  ( o_dbg_val  )
  );

  initial i_clk = 1'b0;
  always #10 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_state = lcg_step(stim_state);
    return stim_state;
  endfunction

  function automatic logic [WB-1:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = stim_rand();
    lo = stim_rand();
    return {hi, lo};
  endfunction

  // Uniform-ish value below m, since 2^256 < 2m for both moduli
  function automatic logic [NB-1:0] rand_below(input logic [NB-1:0] m);
    logic [NB-1:0] v;
    v = '0;
    for (int i = 0; i < NB / 32; i++) begin
      v = {v[NB-33:0], stim_rand()};
    end
    if (v >= m) begin
      v = v - m;
    end
    return v;
  endfunction

  function automatic logic [NB-1:0] mod_mul(input logic [NB-1:0] a, input logic [NB-1:0] b,
                                            input logic [NB-1:0] m);
    logic [2*NB-1:0] full;
    logic [2*NB-1:0] rem;
    full = {{NB{1'b0}}, a} * {{NB{1'b0}}, b};
    rem  = full % {{NB{1'b0}}, m};
    return rem[NB-1:0];
  endfunction

  // Reply layout: status, index, then product LSW first
  function automatic logic [WB-1:0] expected_word(input int w);
    if (w == 0) begin
      return {{(WB-1){1'b0}}, exp_status[0]};
    end else if (w == 1) begin
      return exp_index[0];
    end else begin
      return exp_prod[0][(w-2)*WB +: WB];
    end
  endfunction

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [WB-1:0] expected,
                             input logic [WB-1:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic send_word(input logic [WB-1:0] dat, input logic sop, input logic eop);
    @(negedge i_clk);
    i_cmd_dat = dat;
    i_cmd_val = 1'b1;
    i_cmd_sop = sop;
    i_cmd_eop = eop;
    @(posedge i_clk);
    while (!o_cmd_rdy) begin
      @(posedge i_clk);
    end
  endtask

  task automatic send_mult(input logic sel, input logic [NB-1:0] a, input logic [NB-1:0] b);
    logic [WB-1:0] hdr;
    logic [WB-1:0] idx;
    logic [NB-1:0] m;
    logic          oor;
    hdr      = rand64();
    hdr[8:0] = {sel, `SECP_CMD_MULT_MOD};
    idx      = rand64();
    m        = sel ? N_ORDER : P_PRIME;
    oor      = (a >= m) || (b >= m);
    exp_status.push_back(oor);
    exp_index.push_back(idx);
    if (oor) begin
      exp_prod.push_back('0);
    end else begin
      exp_prod.push_back(mod_mul(a, b, m));
    end
    cmds_sent++;
    last_rf[`SECP_RF_HDR] = hdr;
    last_rf[`SECP_RF_IDX] = idx;
    for (int i = 0; i < `SECP_OP_WORDS; i++) begin
      last_rf[`SECP_RF_A + i] = a[i*WB +: WB];
      last_rf[`SECP_RF_B + i] = b[i*WB +: WB];
    end
    send_word(hdr, 1'b1, 1'b0);
    send_word(idx, 1'b0, 1'b0);
    for (int i = 0; i < `SECP_OP_WORDS; i++) begin
      send_word(a[i*WB +: WB], 1'b0, 1'b0);
    end
    for (int i = 0; i < `SECP_OP_WORDS; i++) begin
      send_word(b[i*WB +: WB], 1'b0, i == `SECP_OP_WORDS - 1);
    end
  endtask

  task automatic send_random_mult(input logic sel);
    logic [NB-1:0] m;
    logic [NB-1:0] a;
    logic [NB-1:0] b;
    m = sel ? N_ORDER : P_PRIME;
    a = rand_below(m);
    b = rand_below(m);
    send_mult(sel, a, b);
  endtask

  // One operand pushed to or just above the modulus
  task automatic send_oor_mult(input logic sel, input logic a_side);
    logic [NB-1:0] m;
    logic [NB-1:0] a;
    logic [NB-1:0] b;
    logic [31:0]   r;
    m = sel ? N_ORDER : P_PRIME;
    a = rand_below(m);
    b = rand_below(m);
    r = stim_rand();
    if (a_side) begin
      a = m + {{(NB-16){1'b0}}, r[15:0]};
    end else begin
      b = m + {{(NB-16){1'b0}}, r[15:0]};
    end
    send_mult(sel, a, b);
  endtask

  task automatic send_skip_packet();
    logic [31:0]   r;
    logic [WB-1:0] hdr;
    int            len;
    r   = stim_rand();
    len = 1 + int'(r[10:8]);
    hdr = rand64();
    if (hdr[7:0] == `SECP_CMD_MULT_MOD) begin
      hdr[7:0] = 8'h11;
    end
    send_word(hdr, 1'b1, len == 1);
    for (int i = 1; i < len; i++) begin
      send_word(rand64(), 1'b0, i == len - 1);
    end
  endtask

  task automatic drain_replies();
    @(negedge i_clk);
    i_cmd_val = 1'b0;
    i_cmd_sop = 1'b0;
    i_cmd_eop = 1'b0;
    while (exp_index.size() != 0) begin
      @(negedge i_clk);
    end
  endtask

  // Valid must show up on the second cycle after the strobe and only there
  task automatic dbg_check(input int addr, input logic [WB-1:0] expected);
    @(negedge i_clk);
    i_dbg_rd   = 1'b1;
    i_dbg_addr = addr[`SECP_RF_ADDR_BITS-1:0];
    @(negedge i_clk);
    i_dbg_rd = 1'b0;
    check_value("o_dbg_val", 1'b0, o_dbg_val);
    @(negedge i_clk);
    check_value("o_dbg_val", 1'b1, o_dbg_val);
    check_value("o_dbg_dat", expected, o_dbg_dat);
    @(negedge i_clk);
    check_value("o_dbg_val", 1'b0, o_dbg_val);
  endtask

  always @(negedge i_clk) begin
    if (rdy_random) begin
      rdy_state = lcg_step(rdy_state);
      i_rpl_rdy = rdy_state[16];
    end else begin
      i_rpl_rdy = 1'b1;
    end
  end

  // Reply monitor
  always @(posedge i_clk) begin
    if (!i_rst && o_rpl_val && i_rpl_rdy) begin
      if (exp_index.size() == 0) begin
        $display("Reply word arrived at %0t with no command outstanding", $time);
        abort_run();
      end else begin
        check_value("o_rpl_sop", rpl_word == 0, o_rpl_sop);
        check_value("o_rpl_eop", rpl_word == `SECP_RPL_WORDS - 1, o_rpl_eop);
        check_value("o_rpl_dat", expected_word(rpl_word), o_rpl_dat);
        if (rpl_word == `SECP_RPL_WORDS - 1) begin
          void'(exp_status.pop_front());
          void'(exp_index.pop_front());
          void'(exp_prod.pop_front());
          rpl_word = 0;
          replies_rcv++;
        end else begin
          rpl_word++;
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with %0d of %0d replies received",
             TIMEOUT_NS, replies_rcv, cmds_sent);
    abort_run();
  end

  initial begin
    logic [31:0] r;
    stim_state  = SEED;
    rdy_state   = SEED;
    rdy_random  = 1'b0;
    rpl_word    = 0;
    cmds_sent   = 0;
    replies_rcv = 0;
    i_rst       = 1'b1;
    i_cmd_dat   = '0;
    i_cmd_val   = 1'b0;
    i_cmd_sop   = 1'b0;
    i_cmd_eop   = 1'b0;
    i_rpl_rdy   = 1'b1;
    i_dbg_rd    = 1'b0;
    i_dbg_addr  = '0;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    check_value("o_cmd_rdy", 1'b0, o_cmd_rdy);
    check_value("o_rpl_val", 1'b0, o_rpl_val);
    check_value("o_dbg_val", 1'b0, o_dbg_val);
    i_rst = 1'b0;

    for (int i = 0; i < N_P_CMDS; i++) begin
      send_random_mult(1'b0);
    end
    drain_replies();
    for (int i = 0; i < N_N_CMDS; i++) begin
      send_random_mult(1'b1);
    end
    drain_replies();

    // Alternate the modulus and which operand is too large
    for (int i = 0; i < N_OOR_CMDS; i++) begin
      send_oor_mult(i[0], i[1]);
    end
    drain_replies();

    // Unknown packets leave no reply behind
    for (int i = 0; i < N_SKIP_CMDS; i++) begin
      send_skip_packet();
      send_random_mult(i[0]);
    end
    drain_replies();

    @(posedge i_clk);
    rdy_random = 1'b1;
    for (int i = 0; i < N_BURST_CMDS; i++) begin
      r = stim_rand();
      send_random_mult(r[20]);
    end
    drain_replies();
    @(posedge i_clk);
    rdy_random = 1'b0;

    for (int addr = `SECP_RF_HDR; addr <= `SECP_RF_B + 3; addr++) begin
      dbg_check(addr, last_rf[addr]);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
